// File: include/exu_cfg.svh
// Execution stage configuration
// Data width, register file addressing and start-up behaviour

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Data and address width
`define EXU_XLEN        32

// Register index width, 32 integer registers
`define EXU_REG_AW      5

// First fetch address after reset
`define EXU_RST_VECTOR  32'h0000_0200

// Cycles from reset release to the start-up jump
`define EXU_INIT_DELAY  3

`endif

// File: list.f
+incdir+include
rtl/exu_pkg.sv
rtl/exu_queue.sv
rtl/exu_ialu.sv
rtl/exu_lsu.sv
rtl/exu_pc.sv
rtl/exu_core.sv
verif/tb_exu.sv

// File: rtl/exu_core.sv
// Execution stage top level
// Operand fetch, write-back and ready logic around the
// queue, ALU, load/store unit and PC blocks

`timescale 1ns/1ps

module exu_core (
    input  logic                clk,
    input  logic                rst_n,
    // Decode
    input  logic                idu_req,
    input  exu_pkg::exu_cmd_t   idu_cmd,
    output logic                idu_rdy,
    // Register file
    output exu_pkg::reg_addr_t  rs1_addr,
    output exu_pkg::reg_addr_t  rs2_addr,
    input  exu_pkg::xlen_t      rs1_data,
    input  exu_pkg::xlen_t      rs2_data,
    output logic                rf_w_req,
    output exu_pkg::rf_wr_t     rf_wr,
    // Data memory
    output logic                dmem_req,
    output exu_pkg::dmem_req_t  dmem,
    input  logic                dmem_req_ack,
    input  logic                dmem_rvalid,
    input  exu_pkg::xlen_t      dmem_rdata,
    // PC
    output exu_pkg::xlen_t      curr_pc,
    output logic                new_pc_req,
    output exu_pkg::xlen_t      new_pc,
    output logic                instret
);

    import exu_pkg::*;

    logic     q_vd;
    exu_cmd_t q_cmd;
    logic     exu_rdy;
    xlen_t    ialu_op1, ialu_op2, sum2_op1;
    xlen_t    ialu_res, sum2_res;
    logic     ialu_cmp;
    logic     lsu_req, lsu_rdy;
    xlen_t    lsu_l_data;
    logic     jump_taken;  // Jump or taken branch
    xlen_t    inc_pc;

    exu_queue u_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .idu_req (idu_req),
        .idu_cmd (idu_cmd),
        .exu_rdy (exu_rdy),
        .flush   (new_pc_req),
        .idu_rdy (idu_rdy),
        .q_vd    (q_vd),
        .q_cmd   (q_cmd)
    );

    //--------------------------------------------------
    // Operand fetch
    //--------------------------------------------------
    assign rs1_addr = q_cmd.rs1_addr;
    assign rs2_addr = q_cmd.rs2_addr;
    assign ialu_op1 = rs1_data;
    assign ialu_op2 = (q_cmd.ialu_op == IALU_OP_REG_REG) ? rs2_data : q_cmd.imm;
    assign sum2_op1 = (q_cmd.sum2_op == SUM2_OP_REG_IMM) ? rs1_data : curr_pc;  // JALR vs JAL/branch

    exu_ialu u_ialu (
        .op1      (ialu_op1),
        .op2      (ialu_op2),
        .sum2_op1 (sum2_op1),
        .sum2_op2 (q_cmd.imm),
        .cmd      (q_cmd.ialu_cmd),
        .res      (ialu_res),
        .sum2_res (sum2_res),
        .cmp      (ialu_cmp)
    );

    assign lsu_req = q_vd & (q_cmd.lsu_cmd != LSU_CMD_NONE);

    exu_lsu u_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (lsu_req),
        .cmd          (q_cmd.lsu_cmd),
        .addr         (sum2_res),      // rs1 + imm
        .s_data       (rs2_data),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rdata   (dmem_rdata),
        .rdy          (lsu_rdy),
        .l_data       (lsu_l_data),
        .dmem_req     (dmem_req),
        .dmem         (dmem)
    );

    //--------------------------------------------------
    // Ready, retire and redirect
    //--------------------------------------------------
    assign exu_rdy    = lsu_req ? lsu_rdy : 1'b1;  // Only memory ops stall
    assign instret    = q_vd & exu_rdy;
    assign jump_taken = q_vd & (q_cmd.jump_req | (q_cmd.branch_req & ialu_cmp));

    exu_pc u_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire     (instret),
        .jump       (jump_taken),
        .target     (sum2_res),
        .curr_pc    (curr_pc),
        .inc_pc     (inc_pc),
        .new_pc     (new_pc),
        .new_pc_req (new_pc_req)
    );

    // Write-back
    assign rf_w_req   = instret & (q_cmd.rd_wb_sel != RD_WB_NONE);
    assign rf_wr.addr = q_cmd.rd_addr;

    always_comb begin
        case (q_cmd.rd_wb_sel)
            RD_WB_SUM2:   rf_wr.data = sum2_res;    // AUIPC
            RD_WB_IMM:    rf_wr.data = q_cmd.imm;   // LUI
            RD_WB_INC_PC: rf_wr.data = inc_pc;      // Link address
            RD_WB_LSU:    rf_wr.data = lsu_l_data;
            default:      rf_wr.data = ialu_res;
        endcase
    end

endmodule

// File: rtl/exu_ialu.sv
// Integer ALU
// Arithmetic, logic, shifts, set-less-than and branch compare,
// plus a second adder for memory addresses and jump targets

`timescale 1ns/1ps

module exu_ialu (
    input  exu_pkg::xlen_t     op1,
    input  exu_pkg::xlen_t     op2,
    input  exu_pkg::xlen_t     sum2_op1,
    input  exu_pkg::xlen_t     sum2_op2,
    input  exu_pkg::ialu_cmd_e cmd,
    output exu_pkg::xlen_t     res,
    output exu_pkg::xlen_t     sum2_res,
    output logic               cmp
);

    import exu_pkg::*;

    localparam int SHW = $clog2($bits(xlen_t));  // Shift amount width

    logic           eq;     // op1 == op2
    logic           lt_s;   // Signed less than
    logic           lt_u;   // Unsigned less than
    logic [SHW-1:0] shamt;

    assign eq    = (op1 == op2);
    assign lt_s  = ($signed(op1) < $signed(op2));
    assign lt_u  = (op1 < op2);
    assign shamt = op2[SHW-1:0];  // Upper bits ignored

    // Main result
    always_comb begin
        case (cmd)
            IALU_CMD_ADD:  res = op1 + op2;
            IALU_CMD_SUB:  res = op1 - op2;
            IALU_CMD_AND:  res = op1 & op2;
            IALU_CMD_OR:   res = op1 | op2;
            IALU_CMD_XOR:  res = op1 ^ op2;
            IALU_CMD_SLL:  res = op1 << shamt;
            IALU_CMD_SRL:  res = op1 >> shamt;
            IALU_CMD_SRA:  res = xlen_t'($signed(op1) >>> shamt);  // Keeps sign bit
            IALU_CMD_SLT:  res = xlen_t'(lt_s);
            IALU_CMD_SLTU: res = xlen_t'(lt_u);
            default:       res = '0;
        endcase
    end

    // Branch condition
    always_comb begin
        case (cmd)
            IALU_CMD_EQ:  cmp = eq;
            IALU_CMD_NE:  cmp = ~eq;
            IALU_CMD_LT:  cmp = lt_s;
            IALU_CMD_GE:  cmp = ~lt_s;
            IALU_CMD_LTU: cmp = lt_u;
            IALU_CMD_GEU: cmp = ~lt_u;
            default:      cmp = 1'b0;
        endcase
    end

    assign sum2_res = sum2_op1 + sum2_op2;  // Address / target adder

endmodule

// File: rtl/exu_lsu.sv
// Load/store unit
// Issues one data memory request per command, waits for the
// response and extends loaded bytes and halfwords

`timescale 1ns/1ps

module exu_lsu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,          // Queued memory command
    input  exu_pkg::lsu_cmd_e   cmd,
    input  exu_pkg::xlen_t      addr,
    input  exu_pkg::xlen_t      s_data,       // Store data, low bits
    input  logic                dmem_req_ack,
    input  logic                dmem_rvalid,
    input  exu_pkg::xlen_t      dmem_rdata,
    output logic                rdy,          // Command done this cycle
    output exu_pkg::xlen_t      l_data,
    output logic                dmem_req,
    output exu_pkg::dmem_req_t  dmem
);

    import exu_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_RESP} lsu_state_e;

    lsu_state_e state;

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= dmem_req_ack ? WAIT_RESP : WAIT_ACK;  // Ack may come at once
                    end
                end
                WAIT_ACK: begin
                    if (dmem_req_ack) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (dmem_rvalid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign dmem_req = req & (state != WAIT_RESP);  // Held until acknowledged
    assign rdy      = (state == WAIT_RESP) & dmem_rvalid;

    // Request payload, stable while the command sits in the queue
    always_comb begin
        dmem.addr  = addr;
        dmem.wdata = s_data;
        case (cmd)
            LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW: dmem.cmd = MEM_CMD_WR;
            default:                            dmem.cmd = MEM_CMD_RD;
        endcase
        case (cmd)
            LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_SB: dmem.width = MEM_WIDTH_BYTE;
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: dmem.width = MEM_WIDTH_HWORD;
            default:                             dmem.width = MEM_WIDTH_WORD;
        endcase
    end

    // Load data extension
    always_comb begin
        case (cmd)
            LSU_CMD_LB:  l_data = xlen_t'($signed(dmem_rdata[7:0]));
            LSU_CMD_LH:  l_data = xlen_t'($signed(dmem_rdata[15:0]));
            LSU_CMD_LBU: l_data = xlen_t'(dmem_rdata[7:0]);
            LSU_CMD_LHU: l_data = xlen_t'(dmem_rdata[15:0]);
            default:     l_data = dmem_rdata;  // LW
        endcase
    end

endmodule

// File: rtl/exu_pc.sv
// Program counter
// Start-up jump to the reset vector, new-PC select and PC update

`timescale 1ns/1ps

`include "exu_cfg.svh"

module exu_pc (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           retire,      // Instruction leaves the stage
    input  logic           jump,        // Jump or taken branch
    input  exu_pkg::xlen_t target,      // Adder result
    output exu_pkg::xlen_t curr_pc,
    output exu_pkg::xlen_t inc_pc,
    output exu_pkg::xlen_t new_pc,
    output logic           new_pc_req
);

    import exu_pkg::*;

    localparam int INIT_W = `EXU_INIT_DELAY + 1;

    logic [INIT_W-1:0] init_v;   // Fills with ones after reset
    logic              init_pc;  // One-cycle start-up redirect

    //--------------------------------------------------
    // Start-up sequence
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_v <= '0;
        end else if (!(&init_v)) begin
            init_v <= {init_v[INIT_W-2:0], 1'b1};  // Saturates at all ones
        end
    end

    assign init_pc = init_v[INIT_W-2] & ~init_v[INIT_W-1];

    //--------------------------------------------------
    // New PC
    //--------------------------------------------------
    assign new_pc_req = init_pc | jump;
    assign new_pc     = init_pc ? xlen_t'(`EXU_RST_VECTOR)
                                : {target[$bits(xlen_t)-1:1], 1'b0};  // Clear bit 0
    assign inc_pc     = curr_pc + xlen_t'(4);  // No compressed instructions

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= xlen_t'(`EXU_RST_VECTOR);
        end else if (retire || init_pc) begin
            curr_pc <= new_pc_req ? new_pc : inc_pc;
        end
    end

endmodule

// File: rtl/exu_pkg.sv
// Execution stage package
// Opcode and selector enums, decoded command and port structs

`include "exu_cfg.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]   xlen_t;      // Data word
    typedef logic [`EXU_REG_AW-1:0] reg_addr_t;  // Register index

    typedef enum logic {IALU_OP_REG_REG, IALU_OP_REG_IMM} ialu_op_e;   // ALU op2 source
    typedef enum logic {SUM2_OP_PC_IMM, SUM2_OP_REG_IMM} sum2_op_e;    // Adder op1 source

    typedef enum logic [4:0] {
        IALU_CMD_NONE, IALU_CMD_ADD, IALU_CMD_SUB, IALU_CMD_AND, IALU_CMD_OR,
        IALU_CMD_XOR, IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA, IALU_CMD_SLT,
        IALU_CMD_SLTU,
        IALU_CMD_EQ, IALU_CMD_NE, IALU_CMD_LT, IALU_CMD_GE, IALU_CMD_LTU,  // Branch compares
        IALU_CMD_GEU
    } ialu_cmd_e;

    typedef enum logic [3:0] {
        LSU_CMD_NONE, LSU_CMD_LB, LSU_CMD_LH, LSU_CMD_LW, LSU_CMD_LBU,
        LSU_CMD_LHU, LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW
    } lsu_cmd_e;

    typedef enum logic [2:0] {
        RD_WB_NONE, RD_WB_IALU, RD_WB_SUM2, RD_WB_IMM, RD_WB_INC_PC, RD_WB_LSU
    } rd_wb_sel_e;

    typedef enum logic {MEM_CMD_RD, MEM_CMD_WR} mem_cmd_e;
    typedef enum logic [1:0] {MEM_WIDTH_BYTE, MEM_WIDTH_HWORD, MEM_WIDTH_WORD} mem_width_e;

    //--------------------------------------------------
    // Structs
    //--------------------------------------------------
    typedef struct packed {
        ialu_op_e   ialu_op;
        ialu_cmd_e  ialu_cmd;
        sum2_op_e   sum2_op;
        lsu_cmd_e   lsu_cmd;
        rd_wb_sel_e rd_wb_sel;
        logic       jump_req;     // JAL / JALR
        logic       branch_req;   // Conditional branch
        reg_addr_t  rs1_addr;
        reg_addr_t  rs2_addr;
        reg_addr_t  rd_addr;
        xlen_t      imm;          // Already sign-extended by decode
    } exu_cmd_t;

    typedef struct packed {
        mem_cmd_e   cmd;
        mem_width_e width;
        xlen_t      addr;
        xlen_t      wdata;        // Low bits, not shifted to lane
    } dmem_req_t;

    typedef struct packed {
        reg_addr_t  addr;
        xlen_t      data;
    } rf_wr_t;

endpackage

// File: rtl/exu_queue.sv
// One-entry instruction queue
// Holds the decoded command between decode and execute

`timescale 1ns/1ps

module exu_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              idu_req,    // Decode offers a command
    input  exu_pkg::exu_cmd_t idu_cmd,
    input  logic              exu_rdy,    // Queued command completes this cycle
    input  logic              flush,      // Redirect, drop incoming command
    output logic              idu_rdy,
    output logic              q_vd,
    output exu_pkg::exu_cmd_t q_cmd
);

    import exu_pkg::*;

    assign idu_rdy = exu_rdy;  // Accept whenever the slot frees up

    // Valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_vd <= 1'b0;
        end else if (exu_rdy) begin
            q_vd <= idu_req & ~flush;  // Redirect kills the command behind it
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (idu_req && idu_rdy) begin
            q_cmd <= idu_cmd;
        end
    end

endmodule

// File: run.sh
#!/bin/bash
# Build and run the execution stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_exu \
    --Mdir obj_dir -o tb_exu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_exu_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -q "^Finished with no errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

// File: verif/exu_stimulus.txt
// ctrl regs imm rs1_val rs2_val load_data flags wdata mem_addr mem_wdata new_pc
// ctrl: op cmd sum2 lsu wb jump branch; regs: rs1 rs2 rd; flags: shadow we redir mem width
00100100 010203 00000000 00000005 00000007 00000000 01000 0000000c 00000000 00000000 00000000
00200100 040506 00000000 00000003 00000005 00000000 01000 fffffffe 00000000 00000000 00000000
10300100 070008 0000ff0f 12345678 00000000 00000000 01000 00005608 00000000 00000000 00000000
00400100 090a0b 00000000 a0f00000 0000ff01 00000000 01000 a0f0ff01 00000000 00000000 00000000
10500100 0c000d 0000ffff ffff0000 00000000 00000000 01000 ffffffff 00000000 00000000 00000000
00600100 0e0f10 00000000 00000003 00000024 00000000 01000 00000030 00000000 00000000 00000000
10700100 110012 0000001f 80000000 00000000 00000000 01000 00000001 00000000 00000000 00000000
00800100 131415 00000000 80000010 00000004 00000000 01000 f8000001 00000000 00000000 00000000
00900100 161718 00000000 ffffffff 00000001 00000000 01000 00000001 00000000 00000000 00000000
10a00100 19001a 00000001 ffffffff 00000000 00000000 01000 00000000 00000000 00000000 00000000
00000300 00001b 12345000 00000000 00000000 00000000 01000 12345000 00000000 00000000 00000000
00000200 00001c 00001000 00000000 00000000 00000000 01000 0000122c 00000000 00000000 00000000
00000410 00001d 00000100 00000000 00000000 00000000 01100 00000234 00000000 00000000 00000330
00010410 01001e 00000010 00000401 00000000 00000000 01100 00000334 00000000 00000000 00000410
00100100 02031f 00000000 00000000 00000000 00000000 10000 00000000 00000000 00000000 00000000
00b00001 040500 fffffff0 0000abcd 0000abcd 00000000 00100 00000000 00000000 00000000 00000400
00900100 06071e 00000000 00000000 00000000 00000000 10000 00000000 00000000 00000000 00000000
00c00001 080900 00000040 00000005 00000005 00000000 00000 00000000 00000000 00000000 00000000
00d00001 0a0b00 00000020 ffffff00 00000010 00000000 00100 00000000 00000000 00000000 00000424
01000001 0c0d00 00000008 00000001 fffffffe 00000000 00000 00000000 00000000 00000000 00000000
00018000 0e0f00 00000024 00001000 deadbeef 00000000 00012 00000000 00001024 deadbeef 00000000
00016000 101100 fffffffc 00002000 000000a5 00000000 00010 00000000 00001ffc 000000a5 00000000
00017000 121300 00000001 00003001 00001234 00000000 00011 00000000 00003002 00001234 00000000
00011500 14151f 00000003 00004000 00000000 00000080 01010 ffffff80 00004003 00000000 00000000
00014500 16171e 00000000 00004000 00000000 123456f0 01010 000000f0 00004000 00000000 00000000
00012500 18191d 00000002 00005000 00000000 00008001 01011 ffff8001 00005002 00000000 00000000
00015500 1a1b1c 00000004 00005000 00000000 abcd9876 01011 00009876 00005004 00000000 00000000
00013500 1c1d1b fffffff8 00006000 00000000 cafef00d 01012 cafef00d 00005ff8 00000000 00000000
10100100 1f0001 00000001 7fffffff 00000000 00000000 01000 80000000 00000000 00000000 00000000

// File: verif/tb_exu.sv
// Execution stage testbench
// Streams decoded commands from the stimulus file, models the register
// file and a data memory with random delays, and checks write-back,
// memory requests and PC redirects

`timescale 1ns/1ps

`include "exu_cfg.svh"

module tb_exu;

    import exu_pkg::*;

    localparam int NUM_LINES = 29;   // Commands in the stimulus file
    localparam int NUM_COLS  = 11;   // Hex words per line
    localparam int TIMEOUT   = 200;  // Cycles per wait loop

    logic        clk;
    logic        rst_n;
    logic        idu_req;
    logic        idu_rdy;
    exu_cmd_t    idu_cmd;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    logic        rf_w_req;
    rf_wr_t      rf_wr;
    logic        dmem_req;
    dmem_req_t   dmem;
    logic        dmem_req_ack;
    logic        dmem_rvalid;
    xlen_t       dmem_rdata;
    xlen_t       curr_pc;
    logic        new_pc_req;
    xlen_t       new_pc;
    logic        instret;

    logic [31:0] stim [0:NUM_LINES*NUM_COLS-1];
    xlen_t       rf_model [0:31];  // Operand values per register
    xlen_t       load_data;        // Returned on the next load
    xlen_t       exp_pc;           // Tracked program counter
    int          mem_phase;        // 0 waits for request, 1 waits to respond
    int          mem_dly;
    int          seed_val;
    int          line_idx;
    logic        has_shadow;

    exu_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .idu_req      (idu_req),
        .idu_cmd      (idu_cmd),
        .idu_rdy      (idu_rdy),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rf_w_req     (rf_w_req),
        .rf_wr        (rf_wr),
        .dmem_req     (dmem_req),
        .dmem         (dmem),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rdata   (dmem_rdata),
        .curr_pc      (curr_pc),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .instret      (instret)
    );

    always #10 clk = ~clk;  // 20 ns period

    //--------------------------------------------------
    // Register file and data memory models
    //--------------------------------------------------
    always @(negedge clk) begin
        rs1_data = rf_model[rs1_addr];  // Same-cycle read data
        rs2_data = rf_model[rs2_addr];
    end

    always @(negedge clk) begin
        dmem_req_ack = 1'b0;
        dmem_rvalid  = 1'b0;
        if (rst_n) begin
            if (mem_phase == 0) begin
                if (dmem_req) begin
                    if (mem_dly == 0) begin
                        dmem_req_ack = 1'b1;
                        mem_phase    = 1;
                        mem_dly      = $urandom % 4;  // Response delay
                    end else begin
                        mem_dly--;
                    end
                end
            end else if (mem_dly == 0) begin
                dmem_rvalid = 1'b1;
                dmem_rdata  = load_data;
                mem_phase   = 0;
                mem_dly     = $urandom % 4;           // Next ack delay
            end else begin
                mem_dly--;
            end
        end
    end

    //--------------------------------------------------
    // Failure and compare tasks
    //--------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s act=%h exp=%h", name, act, exp));
        end
    endtask

    task automatic check_pc(input string name, input xlen_t act, input xlen_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s act=%h exp=%h", name, act, exp));
        end
    endtask

    task automatic check_rf_wr(input rf_wr_t act, input rf_wr_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL rf_wr act=%h exp=%h", act, exp));
        end
    endtask

    task automatic check_dmem(input dmem_req_t act, input dmem_req_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL dmem act=%h exp=%h", act, exp));
        end
    endtask

    // Control word digits: op, cmd(2), sum2, lsu, wb, jump, branch
    function automatic exu_cmd_t decode_cmd(input logic [31:0] ctrl, input logic [31:0] regs,
                                            input xlen_t imm);
        exu_cmd_t c;
        c.ialu_op    = ialu_op_e'(ctrl[28]);
        c.ialu_cmd   = ialu_cmd_e'(ctrl[24:20]);
        c.sum2_op    = sum2_op_e'(ctrl[16]);
        c.lsu_cmd    = lsu_cmd_e'(ctrl[15:12]);
        c.rd_wb_sel  = rd_wb_sel_e'(ctrl[10:8]);
        c.jump_req   = ctrl[4];
        c.branch_req = ctrl[0];
        c.rs1_addr   = regs[20:16];
        c.rs2_addr   = regs[12:8];
        c.rd_addr    = regs[4:0];
        c.imm        = imm;
        return c;
    endfunction

    //--------------------------------------------------
    // One command from offer to retire
    //--------------------------------------------------
    task automatic run_line(input int i, input logic shadow);
        int        base;
        int        nb;
        int        cnt;
        logic      mem_seen;
        logic      is_mem;
        logic      resp_due;
        logic [31:0] flags;
        exu_cmd_t  cmd;
        exu_cmd_t  filler;
        rf_wr_t    exp_wr;
        dmem_req_t exp_mem;
        base = i * NUM_COLS;
        nb   = base + NUM_COLS;
        cmd  = decode_cmd(stim[base], stim[base+1], stim[base+2]);
        flags         = stim[base+6];  // Digits: shadow, write, redirect, memory, width
        is_mem        = flags[4];
        mem_seen      = 1'b0;
        resp_due      = 1'b0;
        filler           = '0;
        filler.rd_wb_sel = RD_WB_IALU;  // Writes x0 if it ever gets in
        exp_wr.addr   = cmd.rd_addr;
        exp_wr.data   = stim[base+7];
        exp_mem.cmd   = (cmd.lsu_cmd inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW}) ?
                        MEM_CMD_WR : MEM_CMD_RD;
        exp_mem.width = mem_width_e'(flags[1:0]);
        exp_mem.addr  = stim[base+8];
        exp_mem.wdata = stim[base+9];
        rf_model[cmd.rs1_addr] = stim[base+3];
        rf_model[cmd.rs2_addr] = stim[base+4];
        load_data              = stim[base+5];

        @(negedge clk);
        idu_req = 1'b1;
        idu_cmd = cmd;
        #1;
        cnt = 0;
        while (!idu_rdy) begin                 // Decode handshake
            cnt++;
            if (cnt > TIMEOUT) abort_run($sformatf("Timeout: line %0d never accepted", i));
            @(negedge clk);
            #1;
        end

        @(negedge clk);                        // Command now queued
        if (shadow) begin
            idu_cmd = decode_cmd(stim[nb], stim[nb+1], stim[nb+2]);  // Offered behind it
        end else if (is_mem) begin
            idu_cmd = filler;                  // Offered during the stall
        end else begin
            idu_req = 1'b0;
        end
        #1;
        cnt = 0;
        while (!instret) begin
            check_flag("rf_w_req", rf_w_req, 1'b0);
            check_flag("new_pc_req", new_pc_req, 1'b0);
            if (is_mem) begin
                check_flag("idu_rdy", idu_rdy, 1'b0);  // Back-pressure
                if (dmem_req) begin
                    check_dmem(dmem, exp_mem);  // Held until ack
                    mem_seen = 1'b1;
                end
            end else begin
                check_flag("dmem_req", dmem_req, 1'b0);
            end
            resp_due = (mem_phase == 1) && (mem_dly == 0);  // Response at next falling edge
            cnt++;
            if (cnt > TIMEOUT) abort_run($sformatf("Timeout: line %0d never retired", i));
            @(negedge clk);
            if (resp_due) begin
                idu_req = 1'b0;                // Retire cycle takes nothing new
            end
            #1;
        end

        // Retire cycle
        if (is_mem && !mem_seen) abort_run($sformatf("Line %0d retired without a request", i));
        check_flag("dmem_req", dmem_req, 1'b0);
        check_flag("rf_w_req", rf_w_req, flags[12]);
        if (flags[12]) check_rf_wr(rf_wr, exp_wr);
        check_flag("new_pc_req", new_pc_req, flags[8]);
        if (flags[8]) begin
            check_pc("new_pc", new_pc, stim[base+10]);
            exp_pc = stim[base+10];
        end else begin
            exp_pc = exp_pc + 32'd4;
        end

        @(negedge clk);
        idu_req = 1'b0;
        #1;
        check_pc("curr_pc", curr_pc, exp_pc);
        repeat (3) begin                       // Discarded or idle, nothing retires
            check_flag("instret", instret, 1'b0);
            check_flag("rf_w_req", rf_w_req, 1'b0);
            @(negedge clk);
            #1;
        end
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        int cnt;
        seed_val     = $urandom(32'h9657b33d);
        clk          = 1'b0;
        rst_n        = 1'b0;
        idu_req      = 1'b0;
        idu_cmd      = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        dmem_req_ack = 1'b0;
        dmem_rvalid  = 1'b0;
        dmem_rdata   = '0;
        load_data    = '0;
        mem_phase    = 0;
        mem_dly      = $urandom % 4;
        for (int r = 0; r < 32; r++) begin
            rf_model[r] = '0;
        end
        $readmemh("verif/exu_stimulus.txt", stim);

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_flag("idu_rdy", idu_rdy, 1'b1);
        check_flag("instret", instret, 1'b0);
        check_flag("rf_w_req", rf_w_req, 1'b0);
        check_flag("dmem_req", dmem_req, 1'b0);
        check_flag("new_pc_req", new_pc_req, 1'b0);

        // Start-up jump to the reset vector
        cnt = 0;
        while (!new_pc_req) begin
            cnt++;
            if (cnt > TIMEOUT) abort_run("Timeout: no start-up redirect after reset");
            @(negedge clk);
            #1;
        end
        check_pc("new_pc", new_pc, `EXU_RST_VECTOR);
        exp_pc = `EXU_RST_VECTOR;
        repeat (5) begin                       // Only one pulse
            @(negedge clk);
            #1;
            check_flag("new_pc_req", new_pc_req, 1'b0);
            check_pc("curr_pc", curr_pc, exp_pc);
        end

        line_idx = 0;
        while (line_idx < NUM_LINES) begin
            has_shadow = 1'b0;
            if (line_idx + 1 < NUM_LINES) begin
                has_shadow = stim[(line_idx + 1) * NUM_COLS + 6][16];
            end
            run_line(line_idx, has_shadow);
            line_idx = line_idx + (has_shadow ? 2 : 1);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule
